/* common/wb_mem_macros.svh */
`ifndef WB_MEM_MACROS_SVH
`define WB_MEM_MACROS_SVH

// bus widths
`define WB_ADR_W 32
`define WB_DAT_W 32
`define WB_SEL_W 4

// bank A, 8 KiB scratchpad
`define BANK_A_BASE 32'h0000_0000
`define BANK_A_AW   11  // word-address bits

// bank B, 32 KiB scratchpad
`define BANK_B_BASE 32'h0001_0000
`define BANK_B_AW   13  // word-address bits

`endif

/* common/wb_mem_pkg.sv */
`default_nettype none

`include "wb_mem_macros.svh"

package wb_mem_pkg;

  // byte address as seen on the bus
  typedef logic [`WB_ADR_W-1:0] wb_adr_t;

  typedef logic [`WB_DAT_W-1:0] wb_dat_t;  // one bus word

  // bit k selects data bits 8k+7..8k
  typedef logic [`WB_SEL_W-1:0] wb_sel_t;

  // one mask bit per data bit
  typedef logic [`WB_DAT_W-1:0] wb_mask_t;

endpackage

`default_nettype wire

/* sram/sram_sp_model.sv */
`default_nettype none

module sram_sp_model #(
  parameter int AW = 11
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 wr_i,
  input  logic                 rd_i,
  input  logic [AW-1:0]        addr_i,
  input  wb_mem_pkg::wb_mask_t wmask_i,
  input  wb_mem_pkg::wb_dat_t  d_i,
  output wb_mem_pkg::wb_dat_t  q_o
);

  import wb_mem_pkg::*;

  localparam int DEPTH = 1 << AW;

  wb_dat_t mem [DEPTH];
  wb_dat_t q_q;

  // bit-masked write, unmasked bits keep their old value
  always_ff @(posedge clk_i) begin
    if (wr_i) begin
      mem[addr_i] <= (mem[addr_i] & ~wmask_i) | (d_i & wmask_i);
    end
  end

  // output latch only updates on a read
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      q_q <= '0;
    end else if (rd_i) begin
      q_q <= mem[addr_i];
    end
  end

  assign q_o = q_q;

  a_rw_excl : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(wr_i && rd_i))
    else $error("read and write requested together");

endmodule

`default_nettype wire

/* sram/wb_sram_port.sv */
`default_nettype none

module wb_sram_port #(
  parameter int AW = 11  // word-address bits of the bank
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                stb_i,
  input  logic                we_i,
  input  wb_mem_pkg::wb_adr_t adr_i,
  input  wb_mem_pkg::wb_sel_t sel_i,
  input  wb_mem_pkg::wb_dat_t dat_i,
  output wb_mem_pkg::wb_dat_t dat_o,
  output logic                ack_o
);

  import wb_mem_pkg::*;

  logic          acc;
  logic          mem_wr;
  logic          mem_rd;
  logic          ack_q;
  logic [AW-1:0] word_adr;
  wb_mask_t      wmask;

  assign acc      = stb_i & ~ack_q;  // no new access in the ack cycle
  assign mem_wr   = acc & we_i;
  assign mem_rd   = acc & ~we_i;
  assign word_adr = adr_i[AW+1:2];

  // each byte select covers eight data bits
  for (genvar k = 0; k < $bits(wb_sel_t); k++) begin : g_mask
    assign wmask[8*k +: 8] = {8{sel_i[k]}};
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= acc;
    end
  end

  sram_sp_model #(
    .AW (AW)
  ) i_sram (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .wr_i    (mem_wr),
    .rd_i    (mem_rd),
    .addr_i  (word_adr),
    .wmask_i (wmask),
    .d_i     (dat_i),
    .q_o     (dat_o)  // valid in the ack cycle
  );

  assign ack_o = ack_q;

  a_ack_pulse : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ack_o |=> !ack_o)
    else $error("ack held for two cycles");

endmodule

`default_nettype wire

/* src/wb_mem_router.sv */
`default_nettype none

`include "wb_mem_macros.svh"

module wb_mem_router (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                cyc_i,
  input  logic                stb_i,
  input  wb_mem_pkg::wb_adr_t adr_i,
  input  logic                bank_a_ack_i,
  input  logic                bank_b_ack_i,
  input  wb_mem_pkg::wb_dat_t bank_a_dat_i,
  input  wb_mem_pkg::wb_dat_t bank_b_dat_i,
  output logic                bank_a_stb_o,
  output logic                bank_b_stb_o,
  output logic                ack_o,
  output logic                err_o,
  output wb_mem_pkg::wb_dat_t dat_o
);

  import wb_mem_pkg::*;

  localparam int      ADR_MSB = $bits(wb_adr_t) - 1;
  localparam int      A_LSB   = `BANK_A_AW + 2;  // lowest bit above bank A
  localparam int      B_LSB   = `BANK_B_AW + 2;  // lowest bit above bank B
  localparam wb_adr_t A_BASE  = `BANK_A_BASE;
  localparam wb_adr_t B_BASE  = `BANK_B_BASE;

  logic req;
  logic hit_a;
  logic hit_b;
  logic miss;
  logic err_q;

  assign req   = cyc_i & stb_i;
  assign hit_a = (adr_i[ADR_MSB:A_LSB] == A_BASE[ADR_MSB:A_LSB]);
  assign hit_b = (adr_i[ADR_MSB:B_LSB] == B_BASE[ADR_MSB:B_LSB]);
  assign miss  = req & ~hit_a & ~hit_b;  // hole in the memory map

  assign bank_a_stb_o = req & hit_a;
  assign bank_b_stb_o = req & hit_b;

  // error response, accepted only while not already answering
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= miss & ~err_q;
    end
  end

  assign ack_o = bank_a_ack_i | bank_b_ack_i;
  assign err_o = err_q;

  always_comb begin
    if (bank_a_ack_i) begin
      dat_o = bank_a_dat_i;
    end else if (bank_b_ack_i) begin
      dat_o = bank_b_dat_i;
    end else begin
      dat_o = '0;  // idle or error cycle
    end
  end

  // only one access in flight, so one kind of response at a time
  a_resp_excl : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(ack_o && err_o))
    else $error("ack_o and err_o asserted in the same cycle");

  // bank windows must not overlap
  a_stb_excl : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(bank_a_stb_o && bank_b_stb_o))
    else $error("both bank strobes asserted");

endmodule

`default_nettype wire

/* src/wb_mem_top.sv */
`default_nettype none

`include "wb_mem_macros.svh"

module wb_mem_top (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                cyc_i,
  input  logic                stb_i,
  input  logic                we_i,
  input  wb_mem_pkg::wb_adr_t adr_i,
  input  wb_mem_pkg::wb_sel_t sel_i,
  input  wb_mem_pkg::wb_dat_t dat_i,
  output wb_mem_pkg::wb_dat_t dat_o,
  output logic                ack_o,
  output logic                err_o
);

  import wb_mem_pkg::*;

  logic    bank_a_stb;
  logic    bank_b_stb;
  logic    bank_a_ack;
  logic    bank_b_ack;
  wb_dat_t bank_a_dat;
  wb_dat_t bank_b_dat;

  wb_mem_router i_router (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .cyc_i        (cyc_i),
    .stb_i        (stb_i),
    .adr_i        (adr_i),
    .bank_a_ack_i (bank_a_ack),
    .bank_b_ack_i (bank_b_ack),
    .bank_a_dat_i (bank_a_dat),
    .bank_b_dat_i (bank_b_dat),
    .bank_a_stb_o (bank_a_stb),
    .bank_b_stb_o (bank_b_stb),
    .ack_o        (ack_o),
    .err_o        (err_o),
    .dat_o        (dat_o)
  );

  // 8 KiB bank
  wb_sram_port #(
    .AW (`BANK_A_AW)
  ) i_bank_a (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .stb_i   (bank_a_stb),
    .we_i    (we_i),
    .adr_i   (adr_i),
    .sel_i   (sel_i),
    .dat_i   (dat_i),
    .dat_o   (bank_a_dat),
    .ack_o   (bank_a_ack)
  );

  // 32 KiB bank
  wb_sram_port #(
    .AW (`BANK_B_AW)
  ) i_bank_b (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .stb_i   (bank_b_stb),
    .we_i    (we_i),
    .adr_i   (adr_i),
    .sel_i   (sel_i),
    .dat_i   (dat_i),
    .dat_o   (bank_b_dat),
    .ack_o   (bank_b_ack)
  );

endmodule

`default_nettype wire

/* test/wb_mem_checker.sv */
`default_nettype none

`include "wb_mem_macros.svh"

module wb_mem_checker (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                cyc_i,
  input  logic                stb_i,
  input  logic                we_i,
  input  wb_mem_pkg::wb_adr_t adr_i,
  input  wb_mem_pkg::wb_sel_t sel_i,
  input  wb_mem_pkg::wb_dat_t wr_dat_i,
  input  wb_mem_pkg::wb_dat_t rd_dat_i,
  input  logic                ack_i,
  input  logic                err_i,
  output int                  value_errs_o,
  output int                  resp_errs_o,
  output int                  checks_o
);

  import wb_mem_pkg::*;

  localparam wb_adr_t A_SPAN   = wb_adr_t'(4) << `BANK_A_AW;  // bytes in bank A
  localparam wb_adr_t B_SPAN   = wb_adr_t'(4) << `BANK_B_AW;
  localparam int      SH_BYTES = int'(A_SPAN + B_SPAN);

  logic [7:0] shadow [SH_BYTES];  // bank A bytes followed by bank B
  bit         known  [SH_BYTES];  // byte written since reset

  int      value_errs;
  int      resp_errs;
  int      checks;
  logic    resp_due;  // response expected in this cycle
  logic    exp_err;
  logic    exp_rd;
  wb_adr_t exp_adr;
  wb_dat_t exp_dat;
  wb_dat_t exp_valid;

  assign value_errs_o = value_errs;
  assign resp_errs_o  = resp_errs;
  assign checks_o     = checks;

  // shadow offset of the addressed word or -1 for a hole in the map
  function automatic int byte_base(input wb_adr_t adr);
    wb_adr_t word_adr;
    word_adr = adr & ~wb_adr_t'(3);
    if ((word_adr & ~(A_SPAN - 1)) == `BANK_A_BASE) begin
      return int'(word_adr - `BANK_A_BASE);
    end else if ((word_adr & ~(B_SPAN - 1)) == `BANK_B_BASE) begin
      return int'(A_SPAN) + int'(word_adr - `BANK_B_BASE);
    end else begin
      return -1;
    end
  endfunction

  // expected read word with a mask of the known bits in valid
  function automatic wb_dat_t expected_word(input wb_adr_t adr, output wb_dat_t valid);
    int      base;
    wb_dat_t word;
    base  = byte_base(adr);
    word  = '0;
    valid = '1;  // unmapped reads return zero
    if (base >= 0) begin
      for (int k = 0; k < 4; k++) begin
        word[8*k +: 8]  = shadow[base + k];
        valid[8*k +: 8] = {8{known[base + k]}};
      end
    end
    return word;
  endfunction

  function automatic void apply_write(input wb_adr_t adr, input wb_sel_t sel,
                                      input wb_dat_t dat);
    int base;
    base = byte_base(adr);
    if (base >= 0) begin
      for (int k = 0; k < 4; k++) begin
        if (sel[k]) begin
          shadow[base + k] = dat[8*k +: 8];
          known[base + k]  = 1'b1;
        end
      end
    end
  endfunction

  task automatic report_value(input string msg);
    $display("CHECK FAILED at %0t: %s", $time, msg);
    value_errs++;
  endtask

  task automatic check_response();
    if (resp_due) begin
      checks++;
      if (!ack_i && !err_i) begin
        $display("missing response: no ack_o or err_o one cycle after access to 0x%08h (%0t)",
                 exp_adr, $time);
        resp_errs++;
      end else if (exp_err) begin
        if (ack_i || !err_i) begin
          report_value($sformatf("0x%08h unmapped, got ack_o=%b err_o=%b",
                                 exp_adr, ack_i, err_i));
        end else if (rd_dat_i !== '0) begin
          report_value($sformatf("error response with data 0x%08h", rd_dat_i));
        end
      end else if (!ack_i || err_i) begin
        report_value($sformatf("0x%08h mapped, got ack_o=%b err_o=%b", exp_adr, ack_i, err_i));
      end else if (exp_rd && (((rd_dat_i ^ exp_dat) & exp_valid) !== '0)) begin
        report_value($sformatf("read 0x%08h returned 0x%08h, expected 0x%08h (known 0x%08h)",
                               exp_adr, rd_dat_i, exp_dat, exp_valid));
      end
    end else if (ack_i || err_i) begin
      report_value($sformatf("response without a request, ack_o=%b err_o=%b", ack_i, err_i));
    end else if (rd_dat_i !== '0) begin
      report_value($sformatf("dat_o is 0x%08h while idle", rd_dat_i));
    end
  endtask

  // a request is taken at the next edge unless a response is on the bus now
  task automatic accept_request();
    if (cyc_i && stb_i && !resp_due) begin
      exp_adr = adr_i;
      exp_err = (byte_base(adr_i) < 0);
      exp_rd  = !we_i;
      exp_dat = expected_word(adr_i, exp_valid);
      if (we_i) begin
        apply_write(adr_i, sel_i, wr_dat_i);
      end
      resp_due = 1'b1;
    end else begin
      resp_due = 1'b0;
    end
  endtask

  // bus sampled at the falling edge between two driving edges
  always @(negedge clk_i) begin
    if (rst_n_i !== 1'b1) begin
      foreach (known[i]) begin
        known[i] = 1'b0;
      end
      resp_due   = 1'b0;
      value_errs = 0;
      resp_errs  = 0;
      checks     = 0;
    end else begin
      check_response();
      accept_request();
    end
  end

endmodule

`default_nettype wire

/* test/tb_wb_mem.sv */
`default_nettype none

`include "wb_mem_macros.svh"

module tb_wb_mem;

  import wb_mem_pkg::*;

  localparam int MAX_CYCLES = 3000;  // ~600 accesses of up to 3 cycles, plus margin
  localparam int RESP_WAIT  = 4;

  logic    clk_i;
  logic    rst_n_i;
  logic    cyc;
  logic    stb;
  logic    we;
  wb_adr_t adr;
  wb_sel_t sel;
  wb_dat_t wdat;
  wb_dat_t rdat;
  logic    ack;
  logic    err;
  int      value_errs;
  int      resp_errs;
  int      checks;
  int      stall_errs;
  int      cycles;

  wb_mem_top i_dut (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .cyc_i   (cyc),
    .stb_i   (stb),
    .we_i    (we),
    .adr_i   (adr),
    .sel_i   (sel),
    .dat_i   (wdat),
    .dat_o   (rdat),
    .ack_o   (ack),
    .err_o   (err)
  );

  wb_mem_checker i_checker (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .cyc_i        (cyc),
    .stb_i        (stb),
    .we_i         (we),
    .adr_i        (adr),
    .sel_i        (sel),
    .wr_dat_i     (wdat),
    .rd_dat_i     (rdat),
    .ack_i        (ack),
    .err_i        (err),
    .value_errs_o (value_errs),
    .resp_errs_o  (resp_errs),
    .checks_o     (checks)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic close_run(input bit timed_out);
    int total;
    total = value_errs + resp_errs + stall_errs + (timed_out ? 1 : 0);
    $display("errors: value %0d, response %0d, handshake %0d, timeout %0d (%0d checks)",
             value_errs, resp_errs, stall_errs, timed_out ? 1 : 0, checks);
    if (total == 0 && checks > 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  endtask

  // one classic cycle, strobe dropped for a cycle after the response
  task automatic bus_access(input logic wr, input wb_adr_t a, input wb_sel_t s,
                            input wb_dat_t d);
    int waited;
    @(posedge clk_i);
    cyc  <= 1'b1;
    stb  <= 1'b1;
    we   <= wr;
    adr  <= a;
    sel  <= s;
    wdat <= d;
    waited = 0;
    do begin
      @(negedge clk_i);
      waited++;
    end while (!(ack || err) && waited < RESP_WAIT);
    if (!(ack || err)) begin
      $display("handshake stalled: no ack or err for access to 0x%08h", a);
      stall_errs++;
    end
    @(posedge clk_i);
    cyc <= 1'b0;
    stb <= 1'b0;
  endtask

  task automatic write_word(input wb_adr_t a, input wb_dat_t d);
    bus_access(1'b1, a, 4'hF, d);
  endtask

  task automatic read_word(input wb_adr_t a);
    bus_access(1'b0, a, 4'hF, 32'h0);
  endtask

  // same offset in both banks, then overwrite A and look at B again
  task automatic bank_pair(input wb_adr_t off_a, input wb_adr_t off_b);
    write_word(`BANK_A_BASE + off_a, 32'hA000_0000 | off_a);
    write_word(`BANK_B_BASE + off_a, 32'hB000_0000 | off_a);
    write_word(`BANK_B_BASE + off_b, 32'hBB00_0000 | off_b);
    write_word(`BANK_A_BASE + off_a, 32'h5A00_0000 | off_a);
    read_word(`BANK_A_BASE + off_a);
    read_word(`BANK_B_BASE + off_a);
    read_word(`BANK_B_BASE + off_b);
  endtask

  task automatic lane_patterns(input wb_adr_t a);
    wb_dat_t d;
    write_word(a, 32'h0F1E_2D3C);
    for (int s = 0; s < 16; s++) begin
      d = 32'hA5C3_5A3C ^ (32'h0101_0101 * wb_dat_t'(s));
      bus_access(1'b1, a, wb_sel_t'(s), d);
      read_word(a);
    end
  endtask

  // strobe held for n edges, banks answer every other cycle
  task automatic held_read(input wb_adr_t a, input int n);
    @(posedge clk_i);
    cyc <= 1'b1;
    stb <= 1'b1;
    we  <= 1'b0;
    adr <= a;
    sel <= 4'hF;
    repeat (n) @(posedge clk_i);
    cyc <= 1'b0;
    stb <= 1'b0;
  endtask

  task automatic random_mix(input int n);
    logic    wr;
    wb_adr_t a;
    wb_sel_t s;
    for (int i = 0; i < n; i++) begin
      case ($urandom_range(7, 0))
        0, 1, 2: a = `BANK_A_BASE + wb_adr_t'($urandom_range(63, 0) << 2);
        3, 4:    a = `BANK_B_BASE + wb_adr_t'($urandom_range(63, 0) << 2);
        5:       a = `BANK_B_BASE + wb_adr_t'($urandom_range((1 << `BANK_B_AW) - 1, 0) << 2);
        6:       a = 32'h0000_2000 + wb_adr_t'($urandom_range(32'h37FF, 0) << 2);  // hole
        default: a = $urandom();
      endcase
      a[1:0] = 2'($urandom_range(3, 0));  // ignored by the decode
      wr = 1'($urandom_range(1, 0));
      s  = wb_sel_t'($urandom_range(15, 0));
      bus_access(wr, a, s, $urandom());
    end
  endtask

  initial begin
    void'($urandom(15));
    stall_errs = 0;
    rst_n_i    = 1'b0;
    cyc        = 1'b0;
    stb        = 1'b0;
    we         = 1'b0;
    adr        = '0;
    sel        = '0;
    wdat       = '0;
    repeat (3) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);
    bank_pair(32'h0000, 32'h0000);
    bank_pair(32'h1000, 32'h4000);
    bank_pair(32'h1FFC, 32'h7FFC);
    lane_patterns(`BANK_A_BASE + 32'h0100);
    lane_patterns(`BANK_B_BASE + 32'h0200);
    write_word(32'h0000_2000, 32'hDEAD_0001);
    write_word(32'h0000_FFFC, 32'hDEAD_0002);
    write_word(32'h0001_8000, 32'hDEAD_0003);
    write_word(32'h8000_0000, 32'hDEAD_0004);
    read_word(32'h0000_2000);
    read_word(32'h0000_FFFC);
    read_word(32'h0001_8000);
    read_word(32'h8000_0000);
    read_word(`BANK_A_BASE);  // aliases of the holes above
    read_word(`BANK_A_BASE + 32'h1FFC);
    read_word(`BANK_B_BASE);
    held_read(`BANK_A_BASE + 32'h1000, 6);
    held_read(`BANK_B_BASE + 32'h4000, 6);
    random_mix(500);
    repeat (3) @(posedge clk_i);
    close_run(1'b0);
  end

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout: run stopped after %0d cycles", MAX_CYCLES);
    close_run(1'b1);
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+common
common/wb_mem_pkg.sv
sram/sram_sp_model.sv
sram/wb_sram_port.sv
src/wb_mem_router.sv
src/wb_mem_top.sv
test/wb_mem_checker.sv
test/tb_wb_mem.sv

/* Makefile */
TOP := tb_wb_mem

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f sources.f --top-module $(TOP)
	verilator --lint-only -f sources.f --top-module wb_mem_top

sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^STATUS: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
